//--- verilog/cpu_pkg.sv
// --------------------
// Shared widths, opcodes and the instruction word layout
// Register file behind the core must be write-through
// --------------------
package cpu_pkg;

    // Widths
    localparam int word_w   = 32;
    localparam int reg_w    = 5;
    localparam int op_w     = 5;
    localparam int imm_w    = 17;
    localparam int target_w = 27;

    localparam logic [reg_w-1:0]  link_reg   = 5'd31;   // jal destination
    localparam logic [reg_w-1:0]  status_reg = 5'd30;   // setx destination
    localparam logic [word_w-1:0] nop_word   = '0;      // add $0, $0, $0

    // -------------------- Opcodes
    localparam logic [op_w-1:0] op_rtype = 5'b00000;
    localparam logic [op_w-1:0] op_j     = 5'b00001;
    localparam logic [op_w-1:0] op_bne   = 5'b00010;
    localparam logic [op_w-1:0] op_jal   = 5'b00011;
    localparam logic [op_w-1:0] op_jr    = 5'b00100;
    localparam logic [op_w-1:0] op_addi  = 5'b00101;
    localparam logic [op_w-1:0] op_blt   = 5'b00110;
    localparam logic [op_w-1:0] op_sw    = 5'b00111;
    localparam logic [op_w-1:0] op_lw    = 5'b01000;
    localparam logic [op_w-1:0] op_setx  = 5'b10101;

    // -------------------- ALU codes
    localparam logic [4:0] alu_add = 5'b00000;
    localparam logic [4:0] alu_sub = 5'b00001;
    localparam logic [4:0] alu_and = 5'b00010;
    localparam logic [4:0] alu_or  = 5'b00011;
    localparam logic [4:0] alu_sll = 5'b00100;
    localparam logic [4:0] alu_sra = 5'b00101;

    // Operand source for X
    localparam logic [1:0] fwd_reg = 2'd0;
    localparam logic [1:0] fwd_w   = 2'd1;
    localparam logic [1:0] fwd_m   = 2'd2;

    // Three views of one instruction word
    typedef union packed {
        struct packed {
            logic [op_w-1:0]  opcode;
            logic [reg_w-1:0] rd;
            logic [reg_w-1:0] rs;
            logic [reg_w-1:0] rt;
            logic [4:0]       shamt;
            logic [4:0]       aluop;
            logic [1:0]       unused;
        } r;
        struct packed {
            logic [op_w-1:0]  opcode;
            logic [reg_w-1:0] rd;
            logic [reg_w-1:0] rs;
            logic [imm_w-1:0] imm;
        } i;
        struct packed {
            logic [op_w-1:0]     opcode;
            logic [target_w-1:0] target;
        } ji;
    } instr_t;

    // Register seen on read port B
    function automatic logic [reg_w-1:0] read_b_reg(instr_t ins);
        logic [reg_w-1:0] idx;
        case (ins.r.opcode)
            op_sw, op_bne, op_blt, op_jr: idx = ins.r.rd;
            default:                      idx = ins.r.rt;
        endcase
        return idx;
    endfunction

    // Written register, 0 when nothing is written
    function automatic logic [reg_w-1:0] dest_reg(instr_t ins);
        logic [reg_w-1:0] dest;
        case (ins.r.opcode)
            op_rtype, op_addi, op_lw: dest = ins.r.rd;
            op_jal:                   dest = link_reg;
            op_setx:                  dest = status_reg;
            default:                  dest = '0;
        endcase
        return dest;
    endfunction

endpackage

//--- verilog/alu.sv
// --------------------
// Integer ALU, compares are signed
// --------------------
`timescale 1ns/1ns

module alu (
    input  logic [cpu_pkg::word_w-1:0] operand_a,
    input  logic [cpu_pkg::word_w-1:0] operand_b,
    input  logic [4:0]                 alu_op,
    input  logic [4:0]                 shamt,
    output logic [cpu_pkg::word_w-1:0] result,
    output logic                       not_equal,
    output logic                       less_than
);

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_add: result = operand_a + operand_b;
            cpu_pkg::alu_sub: result = operand_a - operand_b;
            cpu_pkg::alu_and: result = operand_a & operand_b;
            cpu_pkg::alu_or:  result = operand_a | operand_b;
            cpu_pkg::alu_sll: result = operand_a << shamt;
            cpu_pkg::alu_sra: result = $signed(operand_a) >>> shamt;   // Keeps sign
            default:          result = '0;
        endcase
    end

    // Branch flags, A against B
    assign not_equal = (operand_a != operand_b);
    assign less_than = ($signed(operand_a) < $signed(operand_b));

endmodule

//--- verilog/fetch_stage.sv
// --------------------
// PC and FD register, redirect wins over stall
// --------------------
`timescale 1ns/1ns

module fetch_stage (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       stall,
    input  logic                       redirect,
    input  logic [cpu_pkg::word_w-1:0] target_pc,
    input  logic [cpu_pkg::word_w-1:0] q_imem,
    output logic [cpu_pkg::word_w-1:0] pc_f,
    output logic [cpu_pkg::word_w-1:0] pc_d,
    output cpu_pkg::instr_t            instr_d
);

    logic [cpu_pkg::word_w-1:0] pc_plus1;

    assign pc_plus1 = pc_f + 1'b1;     // Word addressed

    // -------------------- PC
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc_f <= '0;
        end else if (redirect) begin
            pc_f <= target_pc;          // Branch or jump from X
        end else if (!stall) begin
            pc_f <= pc_plus1;
        end
    end

    // -------------------- FD register
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            instr_d <= cpu_pkg::nop_word;
        end else if (redirect) begin
            instr_d <= cpu_pkg::nop_word;   // Kill the wrong-path fetch
        end else if (!stall) begin
            instr_d <= q_imem;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            pc_d <= pc_plus1;           // Link value and branch base
        end
    end

endmodule

//--- verilog/decode_stage.sv
// --------------------
// Register read and DX register
// Read data comes back in the same cycle from the register file
// --------------------
`timescale 1ns/1ns

module decode_stage (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       stall,
    input  logic                       redirect,
    input  logic [cpu_pkg::word_w-1:0] pc_d,
    input  cpu_pkg::instr_t            instr_d,
    input  logic [cpu_pkg::word_w-1:0] data_read_reg_a,
    input  logic [cpu_pkg::word_w-1:0] data_read_reg_b,
    output logic [cpu_pkg::reg_w-1:0]  ctrl_read_reg_a,
    output logic [cpu_pkg::reg_w-1:0]  ctrl_read_reg_b,
    output logic [cpu_pkg::word_w-1:0] pc_x,
    output cpu_pkg::instr_t            instr_x,
    output logic [cpu_pkg::word_w-1:0] a_x,
    output logic [cpu_pkg::word_w-1:0] b_x
);

    // Port A is always rs
    assign ctrl_read_reg_a = instr_d.r.rs;
    // rt for R-type, rd for sw, bne, blt and jr
    assign ctrl_read_reg_b = cpu_pkg::read_b_reg(instr_d);

    // -------------------- DX register
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            instr_x <= cpu_pkg::nop_word;
        end else if (stall || redirect) begin
            instr_x <= cpu_pkg::nop_word;   // Bubble
        end else begin
            instr_x <= instr_d;
        end
    end

    // Payload follows every cycle, the bubble makes it dead
    always_ff @(posedge clock) begin
        pc_x <= pc_d;
        a_x  <= data_read_reg_a;
        b_x  <= data_read_reg_b;
    end

endmodule

//--- verilog/execute_stage.sv
// --------------------
// X stage with branch resolution and the XM register
// Taken branches and jumps resolve here, two younger instructions die
// --------------------
`timescale 1ns/1ns

module execute_stage (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic [cpu_pkg::word_w-1:0] pc_x,
    input  cpu_pkg::instr_t            instr_x,
    input  logic [cpu_pkg::word_w-1:0] a_x,
    input  logic [cpu_pkg::word_w-1:0] b_x,
    input  logic [1:0]                 fwd_sel_a,
    input  logic [1:0]                 fwd_sel_b,
    input  logic [cpu_pkg::word_w-1:0] fwd_m_val,
    input  logic [cpu_pkg::word_w-1:0] fwd_w_val,
    output logic                       redirect,
    output logic [cpu_pkg::word_w-1:0] target_pc,
    output cpu_pkg::instr_t            instr_m,
    output logic [cpu_pkg::word_w-1:0] result_m,
    output logic [cpu_pkg::word_w-1:0] store_m
);

    logic [cpu_pkg::op_w-1:0]   op;
    logic [4:0]                 alu_op;
    logic [cpu_pkg::word_w-1:0] imm32, target32;
    logic [cpu_pkg::word_w-1:0] op_a, op_b, alu_b, alu_res, result_x;
    logic                       use_imm, not_equal, less_than;
    logic                       is_jal, taken;

    // -------------------- Control decode
    assign op       = instr_x.r.opcode;
    assign imm32    = {{(cpu_pkg::word_w-cpu_pkg::imm_w){instr_x.i.imm[cpu_pkg::imm_w-1]}},
                       instr_x.i.imm};
    assign target32 = {{(cpu_pkg::word_w-cpu_pkg::target_w){1'b0}}, instr_x.ji.target};
    assign use_imm  = (op == cpu_pkg::op_addi) || (op == cpu_pkg::op_lw) ||
                      (op == cpu_pkg::op_sw);
    assign is_jal   = (op == cpu_pkg::op_jal);

    always_comb begin
        case (op)
            cpu_pkg::op_rtype:               alu_op = instr_x.r.aluop;
            cpu_pkg::op_bne, cpu_pkg::op_blt: alu_op = cpu_pkg::alu_sub;
            default:                         alu_op = cpu_pkg::alu_add;   // addi, lw, sw
        endcase
    end

    // -------------------- Operand select
    always_comb begin
        case (fwd_sel_a)
            cpu_pkg::fwd_m: op_a = fwd_m_val;
            cpu_pkg::fwd_w: op_a = fwd_w_val;
            default:        op_a = a_x;
        endcase
        case (fwd_sel_b)
            cpu_pkg::fwd_m: op_b = fwd_m_val;
            cpu_pkg::fwd_w: op_b = fwd_w_val;
            default:        op_b = b_x;
        endcase
    end

    assign alu_b = use_imm ? imm32 : op_b;

    alu u_alu (
        .operand_a(op_a), .operand_b(alu_b), .alu_op, .shamt(instr_x.r.shamt),
        .result(alu_res), .not_equal, .less_than
    );

    // -------------------- Branch and jump
    always_comb begin
        taken     = 1'b0;
        target_pc = target32;                         // j and jal
        case (op)
            cpu_pkg::op_bne: begin
                taken     = not_equal;
                target_pc = pc_x + imm32;
            end
            cpu_pkg::op_blt: begin
                taken     = not_equal && !less_than;  // B < A, signed
                target_pc = pc_x + imm32;
            end
            cpu_pkg::op_j, cpu_pkg::op_jal: taken = 1'b1;
            cpu_pkg::op_jr: begin
                taken     = 1'b1;
                target_pc = op_b;
            end
            default: taken = 1'b0;
        endcase
    end

    assign redirect = taken;

    always_comb begin
        if (is_jal) begin
            result_x = pc_x;                          // Link value PC+1
        end else if (op == cpu_pkg::op_setx) begin
            result_x = target32;
        end else begin
            result_x = alu_res;
        end
    end

    // -------------------- XM register
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            instr_m <= cpu_pkg::nop_word;
        end else if (redirect && !is_jal) begin
            instr_m <= cpu_pkg::nop_word;             // Jal keeps its link write
        end else begin
            instr_m <= instr_x;
        end
    end

    always_ff @(posedge clock) begin
        result_m <= result_x;
        store_m  <= op_b;       // sw data, may be patched in M
    end

endmodule

//--- verilog/hazard_unit.sv
// --------------------
// Load-use stall and forwarding selects
// sw store data of a load is patched in M instead of stalling
// --------------------
`timescale 1ns/1ns

module hazard_unit (
    input  cpu_pkg::instr_t instr_d,
    input  cpu_pkg::instr_t instr_x,
    input  cpu_pkg::instr_t instr_m,
    input  cpu_pkg::instr_t instr_w,
    output logic            stall,
    output logic [1:0]      fwd_sel_a,
    output logic [1:0]      fwd_sel_b,
    output logic            fwd_sel_store
);

    logic [cpu_pkg::reg_w-1:0] dest_x, dest_m, dest_w;
    logic [cpu_pkg::op_w-1:0]  op_d;
    logic                      hit_a, hit_b;

    // Reads port A in X
    function automatic logic reads_a(logic [cpu_pkg::op_w-1:0] op);
        return op inside {cpu_pkg::op_rtype, cpu_pkg::op_addi, cpu_pkg::op_lw,
                          cpu_pkg::op_sw, cpu_pkg::op_bne, cpu_pkg::op_blt};
    endfunction

    // Needs port B in X, sw is left out
    function automatic logic reads_b(logic [cpu_pkg::op_w-1:0] op);
        return op inside {cpu_pkg::op_rtype, cpu_pkg::op_bne, cpu_pkg::op_blt,
                          cpu_pkg::op_jr};
    endfunction

    // Nearest producer, M before W
    function automatic logic [1:0] pick(logic [cpu_pkg::reg_w-1:0] src,
                                        logic [cpu_pkg::reg_w-1:0] dm,
                                        logic [cpu_pkg::reg_w-1:0] dw);
        if (dm != '0 && dm == src) begin
            return cpu_pkg::fwd_m;
        end else if (dw != '0 && dw == src) begin
            return cpu_pkg::fwd_w;
        end
        return cpu_pkg::fwd_reg;
    endfunction

    assign dest_x = cpu_pkg::dest_reg(instr_x);
    assign dest_m = cpu_pkg::dest_reg(instr_m);
    assign dest_w = cpu_pkg::dest_reg(instr_w);
    assign op_d   = instr_d.r.opcode;

    // -------------------- Load-use
    assign hit_a = reads_a(op_d) && (instr_d.r.rs == dest_x);
    assign hit_b = reads_b(op_d) && (cpu_pkg::read_b_reg(instr_d) == dest_x);
    assign stall = (instr_x.r.opcode == cpu_pkg::op_lw) && (dest_x != '0) &&
                   (hit_a || hit_b);

    // -------------------- Forwarding
    assign fwd_sel_a = pick(instr_x.r.rs, dest_m, dest_w);
    assign fwd_sel_b = pick(cpu_pkg::read_b_reg(instr_x), dest_m, dest_w);

    // sw in M whose data comes from the instruction in W
    assign fwd_sel_store = (instr_m.r.opcode == cpu_pkg::op_sw) && (dest_w != '0) &&
                           (dest_w == instr_m.r.rd);

endmodule

//--- verilog/mem_wb_stage.sv
// --------------------
// Data memory access, MW register and register writeback
// Stores are written at the clock edge while wren is high
// --------------------
`timescale 1ns/1ns

module mem_wb_stage (
    input  logic                       clock,
    input  logic                       rst_n,
    input  cpu_pkg::instr_t            instr_m,
    input  logic [cpu_pkg::word_w-1:0] result_m,
    input  logic [cpu_pkg::word_w-1:0] store_m,
    input  logic                       fwd_sel_store,
    input  logic [cpu_pkg::word_w-1:0] q_dmem,
    output logic [cpu_pkg::word_w-1:0] address_dmem,
    output logic [cpu_pkg::word_w-1:0] data,
    output logic                       wren,
    output cpu_pkg::instr_t            instr_w,
    output logic [cpu_pkg::word_w-1:0] fwd_m_val,
    output logic [cpu_pkg::word_w-1:0] fwd_w_val,
    output logic                       ctrl_write_enable,
    output logic [cpu_pkg::reg_w-1:0]  ctrl_write_reg,
    output logic [cpu_pkg::word_w-1:0] data_write_reg
);

    logic [cpu_pkg::word_w-1:0] result_w, load_w;

    // -------------------- M stage
    assign address_dmem = result_m;                             // rs + imm
    assign wren         = (instr_m.r.opcode == cpu_pkg::op_sw);
    assign data         = fwd_sel_store ? fwd_w_val : store_m;  // Late load data
    assign fwd_m_val    = result_m;

    // -------------------- MW register
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            instr_w <= cpu_pkg::nop_word;
        end else begin
            instr_w <= instr_m;
        end
    end

    always_ff @(posedge clock) begin
        result_w <= result_m;
        load_w   <= q_dmem;
    end

    // -------------------- W stage
    assign fwd_w_val         = (instr_w.r.opcode == cpu_pkg::op_lw) ? load_w : result_w;
    assign ctrl_write_reg    = cpu_pkg::dest_reg(instr_w);  // rd, $31 or $30
    assign ctrl_write_enable = (ctrl_write_reg != '0);      // $0 never written
    assign data_write_reg    = fwd_w_val;

endmodule

//--- verilog/processor.sv
// --------------------
// Five-stage integer core, all registers on the rising clock edge
// Memories answer in the same cycle, register file is write-through
// --------------------
`timescale 1ns/1ns

module processor (
    input  logic                       clock,
    input  logic                       rst_n,
    // Instruction memory
    output logic [cpu_pkg::word_w-1:0] address_imem,
    input  logic [cpu_pkg::word_w-1:0] q_imem,
    // Data memory
    output logic [cpu_pkg::word_w-1:0] address_dmem,
    output logic [cpu_pkg::word_w-1:0] data,
    output logic                       wren,
    input  logic [cpu_pkg::word_w-1:0] q_dmem,
    // Register file
    output logic                       ctrl_write_enable,
    output logic [cpu_pkg::reg_w-1:0]  ctrl_write_reg,
    output logic [cpu_pkg::reg_w-1:0]  ctrl_read_reg_a,
    output logic [cpu_pkg::reg_w-1:0]  ctrl_read_reg_b,
    output logic [cpu_pkg::word_w-1:0] data_write_reg,
    input  logic [cpu_pkg::word_w-1:0] data_read_reg_a,
    input  logic [cpu_pkg::word_w-1:0] data_read_reg_b
);

    // -------------------- Pipeline wires
    cpu_pkg::instr_t             instr_d, instr_x, instr_m, instr_w;
    logic [cpu_pkg::word_w-1:0]  pc_d, pc_x;                // PC+1 of the stage
    logic [cpu_pkg::word_w-1:0]  a_x, b_x;                  // Register reads in DX
    logic [cpu_pkg::word_w-1:0]  result_m, store_m;
    logic [cpu_pkg::word_w-1:0]  fwd_m_val, fwd_w_val;
    logic [cpu_pkg::word_w-1:0]  target_pc;
    logic                        redirect, stall;
    logic [1:0]                  fwd_sel_a, fwd_sel_b;
    logic                        fwd_sel_store;

    fetch_stage u_fetch (
        .clock, .rst_n, .stall, .redirect, .target_pc, .q_imem,
        .pc_f(address_imem), .pc_d, .instr_d
    );

    decode_stage u_decode (
        .clock, .rst_n, .stall, .redirect, .pc_d, .instr_d,
        .data_read_reg_a, .data_read_reg_b,
        .ctrl_read_reg_a, .ctrl_read_reg_b, .pc_x, .instr_x, .a_x, .b_x
    );

    execute_stage u_execute (
        .clock, .rst_n, .pc_x, .instr_x, .a_x, .b_x,
        .fwd_sel_a, .fwd_sel_b, .fwd_m_val, .fwd_w_val,
        .redirect, .target_pc, .instr_m, .result_m, .store_m
    );

    mem_wb_stage u_mem_wb (
        .clock, .rst_n, .instr_m, .result_m, .store_m, .fwd_sel_store, .q_dmem,
        .address_dmem, .data, .wren, .instr_w, .fwd_m_val, .fwd_w_val,
        .ctrl_write_enable, .ctrl_write_reg, .data_write_reg
    );

    hazard_unit u_hazard (
        .instr_d, .instr_x, .instr_m, .instr_w,
        .stall, .fwd_sel_a, .fwd_sel_b, .fwd_sel_store
    );

endmodule

//--- sim/processor_checker.sv
// --------------------
// Assertions bound to the core ports, clocked on the rising edge
// --------------------
`timescale 1ns/1ns

module processor_checker (
    input logic        clock,
    input logic        rst_n,
    input logic        wren,
    input logic        ctrl_write_enable,
    input logic [4:0]  ctrl_write_reg,
    input logic [31:0] data_write_reg
);

    // Quiet through reset and the cycle after
    assert property (@(posedge clock) !rst_n |=> (!wren && !ctrl_write_enable))
        else $error("write strobe high during or right after reset");

    // A register write carries a known index and value
    assert property (@(posedge clock) ctrl_write_enable |->
                     !$isunknown({ctrl_write_reg, data_write_reg}))
        else $error("register write with unknown index or value");

    // Strobes settle once the pipeline is flushed
    assert property (@(posedge clock) rst_n |-> !$isunknown({wren, ctrl_write_enable}))
        else $error("write strobe unknown after reset");

endmodule

bind processor processor_checker u_checker (
    .clock, .rst_n, .wren, .ctrl_write_enable, .ctrl_write_reg, .data_write_reg
);

//--- sim/tb_processor.sv
// --------------------
// Testbench for the core, program and expected events from sim/processor_stim.txt
// Memories are 256 words, indexed by the low address byte
// Register file model is write-through, all registers start at zero
// --------------------
`timescale 1ns/1ns

module tb_processor;

    logic        clock;
    logic        rst_n;
    logic [31:0] address_imem, q_imem, address_dmem, data, q_dmem;
    logic        wren, ctrl_write_enable;
    logic [4:0]  ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;
    logic [31:0] data_write_reg, data_read_reg_a, data_read_reg_b;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] regs [0:31];
    logic [4:0]  exp_w_reg [$];                 // Ordered register writes
    logic [31:0] exp_w_val [$];
    logic [31:0] exp_s_addr [$];                // Ordered stores
    logic [31:0] exp_s_val [$];
    logic [4:0]  want_reg;
    logic [31:0] want_val, want_addr;
    integer      seed = 24412;
    int          value_errors = 0;
    int          surplus_errors = 0;
    int          missing_errors = 0;
    int          file_errors = 0;
    int          cycles = 0;
    int          limit;

    processor u_processor (.*);

    always #4 clock = ~clock;                   // 8 ns period

    // -------------------- Memory and register file models
    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];
    assign data_read_reg_a = (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_a) ?
                             data_write_reg : regs[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_b) ?
                             data_write_reg : regs[ctrl_read_reg_b];

    // Reads the program and the expected event lists
    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  tag;
        logic [31:0] col_a, col_b;
        fd = $fopen("sim/processor_stim.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file sim/processor_stim.txt could not be opened");
            file_errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%c %h %h", tag, col_a, col_b);
                if (n == 3 && tag == "I") begin
                    imem[col_a[7:0]] = col_b;
                end else if (n == 3 && tag == "W") begin
                    exp_w_reg.push_back(col_a[4:0]);
                    exp_w_val.push_back(col_b);
                end else if (n == 3 && tag == "S") begin
                    exp_s_addr.push_back(col_a);
                    exp_s_val.push_back(col_b);
                end
            end
            $fclose(fd);
        end
    endtask

    // -------------------- Event checks
    always @(posedge clock) begin
        if (ctrl_write_enable) begin
            if (exp_w_reg.size() == 0) begin
                $display("Register write to r%0d not expected at cycle %0d", ctrl_write_reg,
                         cycles);
                surplus_errors++;
            end else begin
                want_reg = exp_w_reg.pop_front();
                want_val = exp_w_val.pop_front();
                if (ctrl_write_reg !== want_reg) begin
                    $display("error ctrl_write_reg expected %h got %h", want_reg,
                             ctrl_write_reg);
                    value_errors++;
                end
                if (data_write_reg !== want_val) begin
                    $display("error data_write_reg expected %h got %h", want_val,
                             data_write_reg);
                    value_errors++;
                end
            end
            regs[ctrl_write_reg] <= data_write_reg;
        end
        if (wren) begin
            if (exp_s_addr.size() == 0) begin
                $display("Store to address %h not expected at cycle %0d", address_dmem,
                         cycles);
                surplus_errors++;
            end else begin
                want_addr = exp_s_addr.pop_front();
                want_val  = exp_s_val.pop_front();
                if (address_dmem !== want_addr) begin
                    $display("error address_dmem expected %h got %h", want_addr,
                             address_dmem);
                    value_errors++;
                end
                if (data !== want_val) begin
                    $display("error data expected %h got %h", want_val, data);
                    value_errors++;
                end
            end
            dmem[address_dmem[7:0]] <= data;
        end
    end

    // -------------------- Main sequence
    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;                       // nop
            dmem[i] = $random(seed);
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        load_stimulus();
        limit = 8 * (exp_w_reg.size() + exp_s_addr.size()) + 64;
        repeat (8) @(posedge clock);
        #1 rst_n = 1'b1;
        if (address_imem !== 32'h0) begin
            $display("error address_imem expected %h got %h", 32'h0, address_imem);
            value_errors++;
        end
        while ((exp_w_reg.size() != 0 || exp_s_addr.size() != 0) && cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        if (cycles >= limit) begin
            $display("Timed out after %0d cycles with %0d writes and %0d stores missing",
                     cycles, exp_w_reg.size(), exp_s_addr.size());
            missing_errors = exp_w_reg.size() + exp_s_addr.size();
        end else begin
            repeat (16) @(posedge clock);       // Catch late surplus events
        end
        $display("Errors: %0d value, %0d surplus, %0d missing, %0d file", value_errors,
                 surplus_errors, missing_errors, file_errors);
        if (value_errors == 0 && surplus_errors == 0 && missing_errors == 0 &&
            file_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sim/processor_stim.txt
# I word_address instruction | W register value | S address value
# All numbers hex, W and S entries in the order they must occur
I 00 28400005
I 01 28820003
I 02 00C22000
I 03 01061004
I 04 01460110
I 05 2981FFF0
I 06 01CC0114
I 07 020A3008
I 08 024A300C
I 09 38C00064
I 0A 39C00065
I 0B 42800064
I 0C 02D41000
I 0D 43000065
I 0E 3B000066
I 0F 10820002
I 10 2B400111
I 11 2B400222
I 12 10420001
I 13 2B800007
I 14 30440002
I 15 2BC00333
I 16 2BC00444
I 17 30820001
I 18 2BC00009
I 19 1800001E
I 1A 08000022
I 1B 2C000555
I 1E 2C400011
I 1F 27C00000
I 20 2C800666
I 21 2C800777
I 22 A8001234
I 23 28020001
I 24 3C400067
I 25 08000025
W 01 00000005
W 02 00000008
W 03 0000000D
W 04 00000008
W 05 00000034
W 06 FFFFFFF0
W 07 FFFFFFFC
W 08 00000004
W 09 0000003D
S 64 0000000D
S 65 FFFFFFFC
W 0A 0000000D
W 0B 00000012
W 0C FFFFFFFC
S 66 FFFFFFFC
W 0E 00000007
W 0F 00000009
W 1F 0000001A
W 11 00000011
W 1E 00001234
S 67 00000011

//--- vlog.f
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/hazard_unit.sv
verilog/mem_wb_stage.sv
verilog/processor.sv
sim/processor_checker.sv
sim/tb_processor.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, the log decides pass or fail
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_processor \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "^Regression passed$" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }
